// File: source/ddr_traffic_pkg.sv
package ddr_traffic_pkg;

	// ------------------------------------------------------------------
	// AXI4 port widths, as the memory port takes them
	// ------------------------------------------------------------------
	localparam int AXI_ADDR_W = 33;	// Byte address
	localparam int AXI_ID_W   = 6;	// AW / B id
	localparam int AXI_RESP_W = 2;	// BRESP code

	// Data pattern
	localparam int LANE_W = 16;	// One lane counter
	// Loaded into lanes at or above the burst length
	localparam logic [LANE_W-1:0] FILL_WORD = 16'h1289;

	// Burst type code
	localparam logic [1:0] BURST_INCR = 2'b01;

	// ------------------------------------------------------------------
	// AXI size code for a beat width in bytes
	// ------------------------------------------------------------------
	// Returns log2 of the byte count, 0 when not a power of two
	function automatic logic [2:0] axsize_for_bytes(input int unsigned bytes);
		logic [2:0] code;
		code = 3'd0;
		for (int i = 0; i < 8; i++)
		begin
			if ((32'd1 << i) == bytes)
			begin
				code = i[2:0];	// 1 byte -> 0, 128 bytes -> 7
			end
		end
		return code;
	endfunction

endpackage

// File: source/burst_addr_gen.sv
module burst_addr_gen
	import ddr_traffic_pkg::*;
#(
	parameter int BURST_LEN = 8,
	parameter int BUS_W = 128,
	parameter logic [AXI_ADDR_W-1:0] START_ADDR = '0,
	parameter logic [AXI_ADDR_W-1:0] STOP_ADDR = 33'h0_0010_0000
)(
	input  logic iCLK,
	input  logic iRST,
	input  logic i_adv,	// One pulse per finished burst
	output logic [AXI_ADDR_W-1:0] o_addr
);

	// Bytes covered by one burst
	localparam int BURST_BYTES = BURST_LEN * (BUS_W / 8);

	// One extra bit so a step past the top of the space is still seen
	logic [AXI_ADDR_W:0] next_addr;
	logic [AXI_ADDR_W-1:0] addr_q;
	logic wrap;

	// ------------------------------------------------------------------
	// Next start address
	// ------------------------------------------------------------------
	always_comb
	begin
		next_addr = {1'b0, addr_q} + (AXI_ADDR_W + 1)'(BURST_BYTES);
		// Reaching or passing the stop point restarts the window
		wrap = (next_addr >= {1'b0, STOP_ADDR});
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			addr_q <= START_ADDR;	// First burst at window base
		end
		else if (i_adv)
		begin
			if (wrap)
			begin
				addr_q <= START_ADDR;
			end
			else
			begin
				addr_q <= next_addr[AXI_ADDR_W-1:0];
			end
		end
	end

	assign o_addr = addr_q;	// Held for the whole burst

endmodule

// File: source/wr_data_pattern.sv
module wr_data_pattern
	import ddr_traffic_pkg::*;
#(
	parameter int BUS_W = 128,
	parameter int BURST_LEN = 8
)(
	input  logic iCLK,
	input  logic iRST,
	input  logic i_adv,	// Step the pattern, once per burst
	output logic [BUS_W-1:0] o_wdata
);

	localparam int LANES = BUS_W / LANE_W;	// 8 lanes on a 128 bit bus

	// Per-lane counters, lane 0 in the low bits of the word
	logic [LANE_W-1:0] lane_q [LANES];

	// ------------------------------------------------------------------
	// Lane counters
	// ------------------------------------------------------------------
	for (genvar x = 0; x < LANES; x++)
	begin : g_lane
		// Lanes inside the burst length count, the rest hold fill
		localparam bit COUNTING = (x < BURST_LEN);

		always_ff @(posedge iCLK)
		begin
			if (iRST)
			begin
				lane_q[x] <= LANE_W'(x);	// Lane x starts at x
			end
			else if (i_adv)
			begin
				if (COUNTING)
				begin
					// Wraps at 16 bits
					lane_q[x] <= lane_q[x] + LANE_W'(BURST_LEN);
				end
				else
				begin
					lane_q[x] <= FILL_WORD;
				end
			end
		end

		// Place the lane in the bus word
		assign o_wdata[x*LANE_W +: LANE_W] = lane_q[x];
	end

endmodule

// File: source/axi_wr_sequence.sv
module axi_wr_sequence
	import ddr_traffic_pkg::*;
#(
	parameter int BUS_W = 128,
	parameter int BURST_LEN = 8,
	parameter logic [AXI_ADDR_W-1:0] START_ADDR = '0,
	parameter logic [AXI_ADDR_W-1:0] STOP_ADDR = 33'h0_0010_0000
)(
	input  logic iCLK,
	input  logic iRST,
	input  logic i_run,	// Level, bursts start only while high
	// Write address channel
	output logic [AXI_ADDR_W-1:0] o_awaddr,
	output logic [7:0] o_awlen,
	output logic [2:0] o_awsize,
	output logic [1:0] o_awburst,
	output logic o_awvalid,
	input  logic i_awready,
	// Write data channel
	output logic [BUS_W-1:0] o_wdata,
	output logic o_wlast,
	output logic o_wvalid,
	input  logic i_wready,
	// Write response channel
	input  logic [AXI_ID_W-1:0] i_bid,
	input  logic [AXI_RESP_W-1:0] i_bresp,
	input  logic i_bvalid,
	output logic o_bready,
	output logic o_wdone	// One pulse per completed burst
);

	localparam int CNT_W = $clog2(BURST_LEN);
	localparam logic [CNT_W-1:0] PRE_LAST = CNT_W'(BURST_LEN - 2);	// Beat before last
	localparam logic [AXI_ID_W-1:0] WR_ID = '0;	// Same id as the tied AWID

	typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_DATA, ST_RESP} state_t;

	state_t state_q;
	logic awvalid_q, wvalid_q, wlast_q, bready_q, wdone_q;
	logic [CNT_W-1:0] beat_cnt;
	logic aw_hs, w_hs, last_hs, b_hs, resp_seen;
	logic aw_tgl, w_tgl, last_tgl, b_tgl;
	logic burst_adv;

	// ------------------------------------------------------------------
	// Handshakes and toggle enables
	// ------------------------------------------------------------------
	assign aw_hs = awvalid_q & i_awready;
	assign w_hs = wvalid_q & i_wready;
	assign last_hs = w_hs & wlast_q;	// Final beat taken
	assign resp_seen = i_bvalid & (i_bid == WR_ID);
	assign b_hs = bready_q & i_bvalid;
	assign burst_adv = b_hs;	// Address and pattern step here

	assign aw_tgl = ((state_q == ST_IDLE) & i_run) | aw_hs;	// Raise / drop
	assign w_tgl = (state_q == ST_ADDR) | last_hs;	// One cycle after AW
	// Flag goes up on the beat before last, down when last is taken
	assign last_tgl = (w_hs & ~wlast_q & (beat_cnt == PRE_LAST)) | last_hs;
	assign b_tgl = ((state_q == ST_RESP) & resp_seen & ~bready_q) | b_hs;

	// ------------------------------------------------------------------
	// FSM, beat counter and valid registers
	// ------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state_q <= ST_IDLE;
			awvalid_q <= 1'b0;
			wvalid_q <= 1'b0;
			wlast_q <= 1'b0;
			bready_q <= 1'b0;
			wdone_q <= 1'b0;
			beat_cnt <= '0;
		end
		else
		begin
			case (state_q)
				ST_IDLE: if (i_run) state_q <= ST_ADDR;
				ST_ADDR: state_q <= ST_DATA;	// Data valid goes up next
				ST_DATA: if (last_hs) state_q <= ST_RESP;
				ST_RESP: if (b_hs) state_q <= ST_IDLE;	// Done cycle is idle
				default: state_q <= ST_IDLE;
			endcase

			if (aw_tgl) awvalid_q <= ~awvalid_q;
			if (w_tgl) wvalid_q <= ~wvalid_q;
			if (last_tgl) wlast_q <= ~wlast_q;
			if (b_tgl) bready_q <= ~bready_q;	// High for one cycle
			wdone_q <= b_hs;

			if (last_hs) beat_cnt <= '0;
			else if (w_hs) beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// Burst start address
	burst_addr_gen #(
		.BURST_LEN (BURST_LEN),
		.BUS_W     (BUS_W),
		.START_ADDR(START_ADDR),
		.STOP_ADDR (STOP_ADDR)
	) i_burst_addr_gen (
		.iCLK  (iCLK),
		.iRST  (iRST),
		.i_adv (burst_adv),
		.o_addr(o_awaddr)
	);

	// Lane counter data, constant across one burst
	wr_data_pattern #(
		.BUS_W    (BUS_W),
		.BURST_LEN(BURST_LEN)
	) i_wr_data_pattern (
		.iCLK   (iCLK),
		.iRST   (iRST),
		.i_adv  (burst_adv),
		.o_wdata(o_wdata)
	);

	// Fixed burst shape
	assign o_awlen = 8'(BURST_LEN - 1);
	assign o_awsize = axsize_for_bytes(BUS_W / 8);
	assign o_awburst = BURST_INCR;
	assign o_awvalid = awvalid_q;
	assign o_wvalid = wvalid_q;
	assign o_wlast = wlast_q;
	assign o_bready = bready_q;
	assign o_wdone = wdone_q;

endmodule

// File: source/wr_burst_meter.sv
module wr_burst_meter (
	input  logic iCLK,
	input  logic iRST,
	input  logic i_awvalid,	// Burst start seen on its rise
	input  logic i_wdone,	// Burst end
	output logic [15:0] o_burst_count,
	output logic [15:0] o_burst_cycles
);

	logic awvalid_d;
	logic run_q;	// Burst in flight
	logic [15:0] run_cnt;
	logic [15:0] run_inc;	// Saturating next count
	logic start;

	assign start = i_awvalid & ~awvalid_d;
	assign run_inc = (run_cnt == 16'hFFFF) ? run_cnt : run_cnt + 16'd1;

	// ------------------------------------------------------------------
	// Cycles from AW rise to done, both ends counted
	// ------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			awvalid_d <= 1'b0;
			run_q <= 1'b0;
			run_cnt <= '0;
			o_burst_count <= '0;
			o_burst_cycles <= '0;
		end
		else
		begin
			awvalid_d <= i_awvalid;
			if (start)
			begin
				run_q <= 1'b1;
				run_cnt <= 16'd1;	// Rise cycle counts as one
			end
			else if (run_q & i_wdone)
			begin
				run_q <= 1'b0;
				o_burst_cycles <= run_inc;	// Done cycle included
				if (o_burst_count != 16'hFFFF)
				begin
					o_burst_count <= o_burst_count + 16'd1;
				end
			end
			else if (run_q)
			begin
				run_cnt <= run_inc;
			end
		end
	end

endmodule

// File: source/ddr_write_traffic_top.sv
module ddr_write_traffic_top
	import ddr_traffic_pkg::*;
#(
	parameter int BUS_W = 128,	// 8 lanes of 16 bits
	parameter int BURST_LEN = 8,	// 2, 4, 8 or 16
	parameter logic [AXI_ADDR_W-1:0] START_ADDR = '0,
	parameter logic [AXI_ADDR_W-1:0] STOP_ADDR = 33'h0_0010_0000
)(
	input  logic iCLK,
	input  logic iRST,
	input  logic i_run,
	// Write address channel
	output logic [AXI_ADDR_W-1:0] o_awaddr,
	output logic [7:0] o_awlen,
	output logic [2:0] o_awsize,
	output logic [1:0] o_awburst,
	output logic o_awvalid,
	input  logic i_awready,
	// Write data channel
	output logic [BUS_W-1:0] o_wdata,
	output logic o_wlast,
	output logic o_wvalid,
	input  logic i_wready,
	// Write response channel
	input  logic [AXI_ID_W-1:0] i_bid,
	input  logic [AXI_RESP_W-1:0] i_bresp,
	input  logic i_bvalid,
	output logic o_bready,
	// Status
	output logic o_wdone,
	output logic [15:0] o_burst_count,
	output logic [15:0] o_burst_cycles,
	output logic [AXI_RESP_W-1:0] o_last_bresp
);

	axi_wr_sequence #(
		.BUS_W     (BUS_W),
		.BURST_LEN (BURST_LEN),
		.START_ADDR(START_ADDR),
		.STOP_ADDR (STOP_ADDR)
	) i_axi_wr_sequence (
		.iCLK     (iCLK),
		.iRST     (iRST),
		.i_run    (i_run),
		.o_awaddr (o_awaddr),
		.o_awlen  (o_awlen),
		.o_awsize (o_awsize),
		.o_awburst(o_awburst),
		.o_awvalid(o_awvalid),
		.i_awready(i_awready),
		.o_wdata  (o_wdata),
		.o_wlast  (o_wlast),
		.o_wvalid (o_wvalid),
		.i_wready (i_wready),
		.i_bid    (i_bid),
		.i_bresp  (i_bresp),
		.i_bvalid (i_bvalid),
		.o_bready (o_bready),
		.o_wdone  (o_wdone)
	);

	// Throughput measurement
	wr_burst_meter i_wr_burst_meter (
		.iCLK          (iCLK),
		.iRST          (iRST),
		.i_awvalid     (o_awvalid),
		.i_wdone       (o_wdone),
		.o_burst_count (o_burst_count),
		.o_burst_cycles(o_burst_cycles)
	);

	// ------------------------------------------------------------------
	// Response code of the latest burst, for status only
	// ------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			o_last_bresp <= '0;	// OKAY
		end
		else if (o_bready & i_bvalid)
		begin
			o_last_bresp <= i_bresp;
		end
	end

endmodule

// File: verification/axi_wr_checker.sv
module axi_wr_checker
	import ddr_traffic_pkg::*;
#(
	parameter int BUS_W = 128
)(
	input logic iCLK,
	input logic iRST,
	input logic i_awvalid,
	input logic i_awready,
	input logic [AXI_ADDR_W-1:0] i_awaddr,
	input logic [7:0] i_awlen,
	input logic i_wvalid,
	input logic i_wready,
	input logic [BUS_W-1:0] i_wdata,
	input logic i_wlast,
	input logic i_bready,
	input logic i_wdone
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_cnt = 0;	// Assertion failures so far

	// ----------------------------------------------------------------------
	// Valid held, payload stable until accepted
	// ----------------------------------------------------------------------
	a_aw_hold: assert property (@(posedge iCLK) disable iff (iRST)
		i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr) && $stable(i_awlen))
	else
	begin
		$error("AWVALID dropped or AW payload changed before AWREADY");
		fail_cnt++;
	end

	a_w_hold: assert property (@(posedge iCLK) disable iff (iRST)
		i_wvalid && !i_wready |=> i_wvalid && $stable(i_wdata) && $stable(i_wlast))
	else
	begin
		$error("WVALID dropped or W payload changed before WREADY");
		fail_cnt++;
	end

	// Last flag only on a valid beat
	a_wlast_valid: assert property (@(posedge iCLK) disable iff (iRST)
		i_wlast |-> i_wvalid)
	else
	begin
		$error("WLAST high without WVALID");
		fail_cnt++;
	end

	// One BREADY cycle per burst, done follows it
	a_bready_once: assert property (@(posedge iCLK) disable iff (iRST)
		i_bready |=> !i_bready && i_wdone)
	else
	begin
		$error("BREADY longer than one cycle or not followed by done");
		fail_cnt++;
	end

	a_done_after_bready: assert property (@(posedge iCLK) disable iff (iRST)
		i_wdone |-> $past(i_bready))
	else
	begin
		$error("Done pulse without a BREADY cycle before it");
		fail_cnt++;
	end

endmodule

bind axi_wr_sequence axi_wr_checker #(
	.BUS_W(BUS_W)
) i_axi_wr_checker (
	.iCLK     (iCLK),
	.iRST     (iRST),
	.i_awvalid(o_awvalid),
	.i_awready(i_awready),
	.i_awaddr (o_awaddr),
	.i_awlen  (o_awlen),
	.i_wvalid (o_wvalid),
	.i_wready (i_wready),
	.i_wdata  (o_wdata),
	.i_wlast  (o_wlast),
	.i_bready (o_bready),
	.i_wdone  (o_wdone)
);

// File: verification/tb_ddr_write_traffic.sv
module tb_ddr_write_traffic
	import ddr_traffic_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int BUS_W = 128;
	localparam int BURST_LEN = 4;	// Lanes 4 to 7 carry the fill word
	localparam int LANES = BUS_W / LANE_W;
	localparam int BURST_BYTES = BURST_LEN * BUS_W / 8;	// 64 bytes
	localparam logic [AXI_ADDR_W-1:0] START_ADDR = 33'h1_0000_1000;	// Bit 32 in use
	localparam logic [AXI_ADDR_W-1:0] STOP_ADDR = 33'h1_0000_1300;	// Twelve bursts per window
	localparam int LIMIT = 200;	// Cycles allowed for one burst

	logic iCLK = 1'b0;
	logic iRST;
	logic i_run, i_awready, i_wready, i_bvalid;
	logic [AXI_ID_W-1:0] i_bid;
	logic [AXI_RESP_W-1:0] i_bresp;
	logic [AXI_ADDR_W-1:0] o_awaddr;
	logic [7:0] o_awlen;
	logic [2:0] o_awsize;
	logic [1:0] o_awburst;
	logic o_awvalid, o_wlast, o_wvalid, o_bready, o_wdone;
	logic [BUS_W-1:0] o_wdata;
	logic [15:0] o_burst_count, o_burst_cycles;
	logic [AXI_RESP_W-1:0] o_last_bresp;

	// Reference model state
	logic [AXI_ADDR_W-1:0] exp_addr;
	logic [LANE_W-1:0] exp_lane [LANES];
	int seed = 32'h3b9e2323;
	int err_cnt = 0;
	int test_err = 0;	// Failed checks in the running test
	int tests_run = 0;
	int tests_failed = 0;
	int done_cnt = 0;	// o_wdone pulses seen
	int last_cycles = 0;
	bit timed_out = 1'b0;

	always #20 iCLK = ~iCLK;	// 40 ns period

	ddr_write_traffic_top #(
		.BUS_W     (BUS_W),
		.BURST_LEN (BURST_LEN),
		.START_ADDR(START_ADDR),
		.STOP_ADDR (STOP_ADDR)
	) i_ddr_write_traffic_top (.*);

	// ----------------------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------------------
	function automatic logic [BUS_W-1:0] model_word();
		logic [BUS_W-1:0] w;
		for (int x = 0; x < LANES; x++)
			w[x*LANE_W +: LANE_W] = exp_lane[x];	// Lane 0 low
		return w;
	endfunction

	task automatic model_reset();
		exp_addr = START_ADDR;
		for (int x = 0; x < LANES; x++)
			exp_lane[x] = LANE_W'(x);
	endtask

	task automatic model_advance();
		for (int x = 0; x < LANES; x++)
			exp_lane[x] = (x < BURST_LEN) ? exp_lane[x] + LANE_W'(BURST_LEN) : FILL_WORD;
		// Reaching or passing the stop point goes back to the start
		if ({1'b0, exp_addr} + 34'(BURST_BYTES) >= {1'b0, STOP_ADDR})
			exp_addr = START_ADDR;
		else
			exp_addr = exp_addr + AXI_ADDR_W'(BURST_BYTES);
	endtask

	task automatic expect_eq(input logic [BUS_W-1:0] got, input logic [BUS_W-1:0] exp,
		input string what);
		assert (got === exp)
		else
		begin
			$display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			test_err++;
		end
	endtask

	task automatic drive_point();
		@(posedge iCLK);
		#2;	// Inputs change just after the edge
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		err_cnt += test_err;
		if (test_err == 0)
			$display("%-20s ok", name);
		else
		begin
			tests_failed++;
			$display("%-20s %0d failed checks", name, test_err);
		end
		test_err = 0;
	endtask

	// ----------------------------------------------------------------------
	// Slave model and falling-edge monitor for one burst
	// ----------------------------------------------------------------------
	task automatic run_burst(input bit stall, input logic [AXI_RESP_W-1:0] resp);
		int aw_stall = 0;
		int w_stall = 0;
		int b_wait = 0;
		int beats = 0;
		int cyc = 0;	// AW rise to done with both ends counted
		int t = 0;
		bit aw_done = 1'b0;
		bit rose = 1'b0;
		bit b_done = 1'b0;
		bit done = 1'b0;
		if (stall)
		begin
			aw_stall = {$random(seed)} % 4;
			w_stall = {$random(seed)} % 4;
			b_wait = {$random(seed)} % 6;
		end
		while (!done && t < LIMIT)
		begin
			drive_point();
			i_run = !rose;	// Low again once the burst has started
			i_awready = (aw_stall == 0);
			i_wready = (w_stall == 0);
			i_bvalid = aw_done && beats == BURST_LEN && !b_done && b_wait == 0;
			i_bresp = resp;
			@(negedge iCLK);
			t++;
			rose |= o_awvalid;
			if (rose)
				cyc++;
			if (aw_done)
				expect_eq(o_awvalid, 1'b0, "AWVALID after handshake");
			else if (o_awvalid)
			begin
				expect_eq(o_awaddr, exp_addr, "AWADDR");
				expect_eq(o_awlen, BURST_LEN - 1, "AWLEN");
				expect_eq(o_awsize, $clog2(BUS_W / 8), "AWSIZE");
				expect_eq(o_awburst, 2'b01, "AWBURST");	// INCR
				if (i_awready)
					aw_done = 1'b1;
				else
					aw_stall--;
			end
			if (o_wvalid)
			begin
				expect_eq(beats < BURST_LEN, 1'b1, "beat inside burst");
				expect_eq(o_wdata, model_word(), "WDATA");
				expect_eq(o_wlast, beats == BURST_LEN - 1, "WLAST");
				if (i_wready)
				begin
					beats++;
					w_stall = stall ? {$random(seed)} % 4 : 0;	// Next beat stall
				end
				else
					w_stall--;
			end
			if (o_bready)
			begin
				expect_eq(i_bvalid, 1'b1, "BVALID during BREADY");
				b_done = 1'b1;
			end
			else if (aw_done && beats == BURST_LEN && b_wait > 0)
				b_wait--;	// Late response
			if (o_wdone)
			begin
				expect_eq(b_done, 1'b1, "response before done");
				done = 1'b1;
			end
		end
		if (!done)
		begin
			$display("Timeout: burst at %0h did not finish within %0d cycles", exp_addr, LIMIT);
			timed_out = 1'b1;
			test_err++;
		end
		else
		begin
			expect_eq(beats, BURST_LEN, "accepted beats");
			done_cnt++;
			last_cycles = cyc;
			model_advance();
			// Meter, address and pattern have moved on by the next cycle
			drive_point();
			@(negedge iCLK);
			expect_eq(o_wdone, 1'b0, "single done pulse");
			expect_eq(o_burst_count, done_cnt, "burst count");
			expect_eq(o_burst_cycles, cyc, "burst cycles");
			expect_eq(o_last_bresp, resp, "last BRESP");
			expect_eq(o_awaddr, exp_addr, "next burst address");
			expect_eq(o_wdata, model_word(), "next burst data");
			expect_eq(o_awvalid, 1'b0, "AWVALID with run low");
		end
	endtask

	// ----------------------------------------------------------------------
	// Directed tests
	// ----------------------------------------------------------------------
	task automatic test_reset();
		repeat (3)
		begin
			@(negedge iCLK);
			expect_eq({o_awvalid, o_wvalid, o_wlast, o_bready, o_wdone}, '0, "controls in reset");
		end
		drive_point();	// Fourth reset edge just passed
		iRST = 1'b0;
		repeat (8)
		begin
			@(negedge iCLK);
			expect_eq({o_awvalid, o_wvalid, o_wlast, o_bready, o_wdone}, '0, "controls idle");
		end
		expect_eq(o_awaddr, START_ADDR, "AWADDR after reset");
		expect_eq(o_wdata, model_word(), "lanes after reset");
		expect_eq(o_burst_count, 0, "burst count after reset");
		finish_test("reset");
	endtask

	task automatic test_single_burst();
		expect_eq(o_awaddr, START_ADDR, "AWADDR before first burst");
		run_burst(1'b0, 2'b00);
		finish_test("single burst");
	endtask

	task automatic test_pattern_advance();
		for (int n = 0; n < 3 && !timed_out; n++)
			run_burst(1'b0, 2'b00);
		finish_test("pattern advance");
	endtask

	task automatic test_back_pressure();
		for (int n = 0; n < 8 && !timed_out; n++)
			run_burst(1'b1, 2'($random(seed)));	// Any response code
		finish_test("back-pressure");
	endtask

	task automatic test_addr_wrap();
		int n = 0;
		while (!timed_out && exp_addr != STOP_ADDR - BURST_BYTES && n < 12)
		begin
			run_burst(1'b0, 2'b00);
			n++;
		end
		expect_eq(o_awaddr, STOP_ADDR - BURST_BYTES, "last address of window");
		if (!timed_out)
			run_burst(1'b0, 2'b00);
		expect_eq(o_awaddr, START_ADDR, "address after wrap");
		finish_test("address wrap");
	endtask

	task automatic test_meter();
		run_burst(1'b1, 2'b10);	// SLVERR
		expect_eq(o_last_bresp, 2'b10, "captured BRESP");
		expect_eq(o_burst_count, done_cnt, "count of done pulses");
		expect_eq(o_burst_cycles, last_cycles, "cycles of last burst");
		finish_test("meter and response");
	endtask

	initial
	begin
		iRST = 1'b1;
		i_run = 1'b0;
		i_awready = 1'b0;
		i_wready = 1'b0;
		i_bvalid = 1'b0;
		i_bid = '0;	// Matches the fixed AW id
		i_bresp = '0;
		model_reset();
		test_reset();
		if (!timed_out)
			test_single_burst();
		if (!timed_out)
			test_pattern_advance();
		if (!timed_out)
			test_back_pressure();
		if (!timed_out)
			test_addr_wrap();
		if (!timed_out)
			test_meter();
		assert (i_ddr_write_traffic_top.i_axi_wr_sequence.i_axi_wr_checker.fail_cnt == 0)
		else
		begin
			$display("Protocol checker flagged assertion failures on the write channels");
			err_cnt++;
		end
		$display("Tests run %0d, tests failed %0d, failed checks %0d",
			tests_run, tests_failed, err_cnt);
		if (err_cnt == 0 && !timed_out)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: flist.f
source/ddr_traffic_pkg.sv
source/burst_addr_gen.sv
source/wr_data_pattern.sv
source/axi_wr_sequence.sv
source/wr_burst_meter.sv
source/ddr_write_traffic_top.sv
verification/axi_wr_checker.sv
verification/tb_ddr_write_traffic.sv

// File: Bender.yml
package:
  name: ddr_write_traffic

sources:
  - files:
      - source/ddr_traffic_pkg.sv
      - source/burst_addr_gen.sv
      - source/wr_data_pattern.sv
      - source/axi_wr_sequence.sv
      - source/wr_burst_meter.sv
      - source/ddr_write_traffic_top.sv
  - target: test
    files:
      - verification/axi_wr_checker.sv
      - verification/tb_ddr_write_traffic.sv
